// ==== hw/zap_wb_pkg.sv ====
package zap_wb_pkg;

        // Default size of the physical register file.
        localparam int PHY_REGS = 22;

        // Indexes 0 to 14 are the general registers.
        // The PC is held by the sequencer and not by the bank.
        localparam int ARCH_PC = 15;

        // Banked link registers for the exception modes.
        localparam int PHY_FIQ_R14 = 16;
        localparam int PHY_IRQ_R14 = 17;
        localparam int PHY_SVC_R14 = 18;
        localparam int PHY_ABT_R14 = 19;
        localparam int PHY_UND_R14 = 20;

        // Alias of the status register held in the mode machine.
        localparam int PHY_CPSR = 21;

        // Processor mode codes.
        localparam logic [4:0] MODE_USR = 5'h10;
        localparam logic [4:0] MODE_FIQ = 5'h11;
        localparam logic [4:0] MODE_IRQ = 5'h12;
        localparam logic [4:0] MODE_SVC = 5'h13;
        localparam logic [4:0] MODE_ABT = 5'h17;
        localparam logic [4:0] MODE_UND = 5'h1B;

        // Vector offsets from the configurable base.
        localparam logic [31:0] VEC_UND  = 32'h04;
        localparam logic [31:0] VEC_SWI  = 32'h08;
        localparam logic [31:0] VEC_PABT = 32'h0C;
        localparam logic [31:0] VEC_DABT = 32'h10;
        localparam logic [31:0] VEC_IRQ  = 32'h18;
        localparam logic [31:0] VEC_FIQ  = 32'h1C;

        // Field layout of a status word.
        typedef struct packed {
                logic        n;
                logic        z;
                logic        c;
                logic        v;
                logic [19:0] rsvd;
                logic        i;
                logic        f;
                logic        t;
                logic [4:0]  mode;
        } psr_fields_t;

        // The raw view serves save, restore and writes.
        // The field view serves decoding.
        typedef union packed {
                logic [31:0] raw;
                psr_fields_t f;
        } psr_word_t;

endpackage

// ==== hw/zap_pc_counter.sv ====
`timescale 1ns/100ps

module zap_pc_counter
(
        input  logic        i_clk,
        input  logic        i_reset,
        input  logic        i_code_stall,
        input  logic        i_data_stall,
        input  logic        i_pipe_stall,
        input  logic        i_clear_from_alu,
        input  logic [31:0] i_pc_from_alu,
        input  logic        i_redirect,
        input  logic [31:0] i_redirect_pc,
        input  logic        i_thumb,
        output logic [31:0] o_pc
);

logic [31:0] pc_nxt;

// Writeback redirects win even over a global stall.
always_comb
begin
        if (i_redirect)
                pc_nxt = {i_redirect_pc[31:1], 1'b0};
        else if (i_code_stall || i_data_stall)
                pc_nxt = o_pc;
        else if (i_clear_from_alu)
                pc_nxt = i_pc_from_alu;
        else if (i_pipe_stall)
                pc_nxt = o_pc;
        else
                // Halfword steps in Thumb state, word steps in ARM state.
                pc_nxt = o_pc + (i_thumb ? 32'd2 : 32'd4);
end

always_ff @(posedge i_clk)
begin
        if (i_reset)
                o_pc <= 32'd0;
        else
                o_pc <= pc_nxt;
end

endmodule

// ==== hw/zap_psr_fsm.sv ====
`timescale 1ns/100ps

module zap_psr_fsm #(
        parameter int PHY_REGS = zap_wb_pkg::PHY_REGS
)
(
        input  logic                        i_clk,
        input  logic                        i_reset,
        input  logic                        i_commit,
        input  logic [$clog2(PHY_REGS)-1:0] i_wr_index,
        input  logic [31:0]                 i_wr_data,
        input  logic [3:0]                  i_flags,
        input  logic                        i_exc_enter,
        input  logic [4:0]                  i_exc_mode,
        input  logic                        i_exc_return,
        input  logic                        i_pc_write_thumb,
        output logic [31:0]                 o_cpsr,
        output logic                        o_psr_flush
);

localparam int IDX_W = $clog2(PHY_REGS);
localparam logic [IDX_W-1:0] PC_IDX   = IDX_W'(zap_wb_pkg::ARCH_PC);
localparam logic [IDX_W-1:0] CPSR_IDX = IDX_W'(zap_wb_pkg::PHY_CPSR);
localparam logic [2:0]       NO_SPSR  = 3'd7;

zap_wb_pkg::psr_word_t cpsr_q;
zap_wb_pkg::psr_word_t cpsr_nxt;
logic [31:0]           spsr_q [5];
logic [2:0]            cur_slot;
logic [2:0]            exc_slot;
logic                  user_mode;
logic                  cpsr_write;

// Maps a mode to its SPSR slot. User mode has no SPSR.
function automatic logic [2:0] spsr_slot(input logic [4:0] mode);
        case (mode)
                zap_wb_pkg::MODE_FIQ: spsr_slot = 3'd0;
                zap_wb_pkg::MODE_IRQ: spsr_slot = 3'd1;
                zap_wb_pkg::MODE_SVC: spsr_slot = 3'd2;
                zap_wb_pkg::MODE_ABT: spsr_slot = 3'd3;
                zap_wb_pkg::MODE_UND: spsr_slot = 3'd4;
                default:              spsr_slot = NO_SPSR;
        endcase
endfunction

assign cur_slot   = spsr_slot(cpsr_q.f.mode);
assign exc_slot   = spsr_slot(i_exc_mode);
assign user_mode  = (cpsr_q.f.mode == zap_wb_pkg::MODE_USR);
assign cpsr_write = i_commit && (i_wr_index == CPSR_IDX);
assign o_cpsr     = cpsr_q.raw;

// Mode or interrupt control changes must flush the pipe.
assign o_psr_flush = cpsr_write && !user_mode && (i_wr_data[7:0] != cpsr_q.raw[7:0]);

always_comb
begin
        cpsr_nxt = cpsr_q;
        if (i_exc_enter)
        begin
                // Entry always lands in ARM state.
                cpsr_nxt.f.mode = i_exc_mode;
                cpsr_nxt.f.t    = 1'b0;
        end
        else if (i_exc_return)
        begin
                if (cur_slot != NO_SPSR)
                        cpsr_nxt.raw = spsr_q[cur_slot];
        end
        else if (i_commit)
        begin
                {cpsr_nxt.f.n, cpsr_nxt.f.z, cpsr_nxt.f.c, cpsr_nxt.f.v} = i_flags;
                if (cpsr_write)
                begin
                        cpsr_nxt.raw = i_wr_data;
                        // User code cannot touch mode, masks or T.
                        if (user_mode)
                                cpsr_nxt.raw[7:0] = cpsr_q.raw[7:0];
                end
                if (i_wr_index == PC_IDX)
                        cpsr_nxt.f.t = i_pc_write_thumb;
        end
end

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                cpsr_q.raw <= {27'd0, zap_wb_pkg::MODE_SVC};
                for (int i = 0; i < 5; i++)
                        spsr_q[i] <= 32'd0;
        end
        else
        begin
                cpsr_q <= cpsr_nxt;
                if (i_exc_enter && (exc_slot != NO_SPSR))
                        spsr_q[exc_slot] <= cpsr_q.raw;
        end
end

endmodule

// ==== hw/zap_redirect_ctrl.sv ====
`timescale 1ns/100ps

module zap_redirect_ctrl #(
        parameter int PHY_REGS = zap_wb_pkg::PHY_REGS
)
(
        input  logic                        i_valid,
        input  logic [$clog2(PHY_REGS)-1:0] i_wr_index,
        input  logic [31:0]                 i_wr_data,
        input  logic                        i_flag_update,
        input  logic                        i_data_abt,
        input  logic                        i_fiq,
        input  logic                        i_irq,
        input  logic                        i_instr_abt,
        input  logic                        i_swi,
        input  logic                        i_und,
        input  logic [31:0]                 i_pc_buf,
        input  logic [31:0]                 i_vector_base,
        input  logic                        i_psr_flush,
        output logic                        o_commit,
        output logic                        o_redirect,
        output logic [31:0]                 o_redirect_pc,
        output logic                        o_link_we,
        output logic [$clog2(PHY_REGS)-1:0] o_link_index,
        output logic [31:0]                 o_link_data,
        output logic                        o_exc_enter,
        output logic [4:0]                  o_exc_mode,
        output logic                        o_exc_return,
        output logic                        o_clear_from_writeback,
        output logic                        o_fiq_ack,
        output logic                        o_irq_ack
);

localparam int IDX_W = $clog2(PHY_REGS);
localparam logic [IDX_W-1:0] PC_IDX = IDX_W'(zap_wb_pkg::ARCH_PC);

logic        exc_any;
logic        pc_write;
logic [31:0] vec_off;

assign exc_any  = i_data_abt | i_fiq | i_irq | i_instr_abt | i_swi | i_und;
assign o_commit = i_valid && !exc_any;
assign pc_write = o_commit && (i_wr_index == PC_IDX);

assign o_exc_enter  = exc_any;
assign o_link_we    = exc_any;
assign o_exc_return = pc_write && i_flag_update;
assign o_redirect   = exc_any || pc_write;
assign o_redirect_pc = exc_any ? (i_vector_base + vec_off) : i_wr_data;
assign o_clear_from_writeback = exc_any || pc_write || i_psr_flush;

// Fixed ranking with data abort first and undefined last.
always_comb
begin
        o_exc_mode   = zap_wb_pkg::MODE_UND;
        o_link_index = IDX_W'(zap_wb_pkg::PHY_UND_R14);
        o_link_data  = i_pc_buf - 32'd4;
        vec_off      = zap_wb_pkg::VEC_UND;
        o_fiq_ack    = 1'b0;
        o_irq_ack    = 1'b0;
        if (i_data_abt)
        begin
                // Aborted data access is retried, so the link keeps PC + 8.
                o_exc_mode   = zap_wb_pkg::MODE_ABT;
                o_link_index = IDX_W'(zap_wb_pkg::PHY_ABT_R14);
                o_link_data  = i_pc_buf;
                vec_off      = zap_wb_pkg::VEC_DABT;
        end
        else if (i_fiq)
        begin
                o_exc_mode   = zap_wb_pkg::MODE_FIQ;
                o_link_index = IDX_W'(zap_wb_pkg::PHY_FIQ_R14);
                vec_off      = zap_wb_pkg::VEC_FIQ;
                o_fiq_ack    = 1'b1;
        end
        else if (i_irq)
        begin
                o_exc_mode   = zap_wb_pkg::MODE_IRQ;
                o_link_index = IDX_W'(zap_wb_pkg::PHY_IRQ_R14);
                vec_off      = zap_wb_pkg::VEC_IRQ;
                o_irq_ack    = 1'b1;
        end
        else if (i_instr_abt)
        begin
                o_exc_mode   = zap_wb_pkg::MODE_ABT;
                o_link_index = IDX_W'(zap_wb_pkg::PHY_ABT_R14);
                vec_off      = zap_wb_pkg::VEC_PABT;
        end
        else if (i_swi)
        begin
                o_exc_mode   = zap_wb_pkg::MODE_SVC;
                o_link_index = IDX_W'(zap_wb_pkg::PHY_SVC_R14);
                vec_off      = zap_wb_pkg::VEC_SWI;
        end
end

endmodule

// ==== hw/zap_reg_bank.sv ====
`timescale 1ns/100ps

module zap_reg_bank #(
        parameter int PHY_REGS = zap_wb_pkg::PHY_REGS
)
(
        input  logic                        i_clk,
        input  logic                        i_reset,
        input  logic                        i_commit,
        input  logic [$clog2(PHY_REGS)-1:0] i_wr_index,
        input  logic [31:0]                 i_wr_data,
        input  logic [$clog2(PHY_REGS)-1:0] i_wr_index_1,
        input  logic [31:0]                 i_wr_data_1,
        input  logic                        i_link_we,
        input  logic [$clog2(PHY_REGS)-1:0] i_link_index,
        input  logic [31:0]                 i_link_data,
        input  logic [31:0]                 i_pc,
        input  logic [31:0]                 i_cpsr,
        input  logic [$clog2(PHY_REGS)-1:0] i_rd_index_0,
        input  logic [$clog2(PHY_REGS)-1:0] i_rd_index_1,
        input  logic [$clog2(PHY_REGS)-1:0] i_rd_index_2,
        input  logic [$clog2(PHY_REGS)-1:0] i_rd_index_3,
        output logic [31:0]                 o_rd_data_0,
        output logic [31:0]                 o_rd_data_1,
        output logic [31:0]                 o_rd_data_2,
        output logic [31:0]                 o_rd_data_3
);

localparam int IDX_W = $clog2(PHY_REGS);
localparam logic [IDX_W-1:0] PC_IDX   = IDX_W'(zap_wb_pkg::ARCH_PC);
localparam logic [IDX_W-1:0] CPSR_IDX = IDX_W'(zap_wb_pkg::PHY_CPSR);

logic [31:0] regs [PHY_REGS];

// PC and CPSR live elsewhere, so the array never takes them.
function automatic logic writable(input logic [IDX_W-1:0] idx);
        writable = (idx != PC_IDX) && (idx != CPSR_IDX) && (int'(idx) < PHY_REGS);
endfunction

// Read mux with the PC and CPSR aliases.
function automatic logic [31:0] rd_mux(input logic [IDX_W-1:0] idx);
        if (idx == PC_IDX)
                rd_mux = i_pc;
        else if (idx == CPSR_IDX)
                rd_mux = i_cpsr;
        else if (int'(idx) < PHY_REGS)
                rd_mux = regs[idx];
        else
                rd_mux = 32'd0;
endfunction

always_comb
begin
        o_rd_data_0 = rd_mux(i_rd_index_0);
        o_rd_data_1 = rd_mux(i_rd_index_1);
        o_rd_data_2 = rd_mux(i_rd_index_2);
        o_rd_data_3 = rd_mux(i_rd_index_3);
end

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                for (int i = 0; i < PHY_REGS; i++)
                        regs[i] <= 32'd0;
        end
        else
        begin
                if (i_commit && writable(i_wr_index))
                        regs[i_wr_index] <= i_wr_data;
                // Port 1 is written last and wins on a shared index.
                if (i_commit && writable(i_wr_index_1))
                        regs[i_wr_index_1] <= i_wr_data_1;
                if (i_link_we && writable(i_link_index))
                        regs[i_link_index] <= i_link_data;
        end
end

endmodule

// ==== hw/zap_writeback_top.sv ====
`timescale 1ns/100ps

module zap_writeback_top #(
        parameter int PHY_REGS = 22
)
(
        input  logic                        i_clk,
        input  logic                        i_reset,
        input  logic                        i_valid,
        input  logic                        i_code_stall,
        input  logic                        i_data_stall,
        input  logic                        i_pipe_stall,
        input  logic                        i_clear_from_alu,
        input  logic [31:0]                 i_pc_from_alu,
        input  logic [$clog2(PHY_REGS)-1:0] i_wr_index,
        input  logic [31:0]                 i_wr_data,
        input  logic [$clog2(PHY_REGS)-1:0] i_wr_index_1,
        input  logic [31:0]                 i_wr_data_1,
        input  logic [3:0]                  i_flags,
        input  logic                        i_flag_update,
        input  logic                        i_data_abt,
        input  logic                        i_fiq,
        input  logic                        i_irq,
        input  logic                        i_instr_abt,
        input  logic                        i_swi,
        input  logic                        i_und,
        input  logic [31:0]                 i_pc_buf,
        input  logic [31:0]                 i_vector_base,
        input  logic [$clog2(PHY_REGS)-1:0] i_rd_index_0,
        input  logic [$clog2(PHY_REGS)-1:0] i_rd_index_1,
        input  logic [$clog2(PHY_REGS)-1:0] i_rd_index_2,
        input  logic [$clog2(PHY_REGS)-1:0] i_rd_index_3,
        output logic [31:0]                 o_rd_data_0,
        output logic [31:0]                 o_rd_data_1,
        output logic [31:0]                 o_rd_data_2,
        output logic [31:0]                 o_rd_data_3,
        output logic [31:0]                 o_pc,
        output logic [31:0]                 o_cpsr,
        output logic                        o_clear_from_writeback,
        output logic                        o_fiq_ack,
        output logic                        o_irq_ack
);

localparam int IDX_W = $clog2(PHY_REGS);

logic                  commit;
logic                  redirect;
logic [31:0]           redirect_pc;
logic                  link_we;
logic [IDX_W-1:0]      link_index;
logic [31:0]           link_data;
logic                  exc_enter;
logic [4:0]            exc_mode;
logic                  exc_return;
logic                  psr_flush;
zap_wb_pkg::psr_word_t cpsr;

assign o_cpsr = cpsr.raw;

zap_redirect_ctrl #(.PHY_REGS(PHY_REGS)) u_redirect (
        .i_valid(i_valid), .i_wr_index(i_wr_index), .i_wr_data(i_wr_data),
        .i_flag_update(i_flag_update), .i_data_abt(i_data_abt), .i_fiq(i_fiq),
        .i_irq(i_irq), .i_instr_abt(i_instr_abt), .i_swi(i_swi), .i_und(i_und),
        .i_pc_buf(i_pc_buf), .i_vector_base(i_vector_base), .i_psr_flush(psr_flush),
        .o_commit(commit), .o_redirect(redirect), .o_redirect_pc(redirect_pc),
        .o_link_we(link_we), .o_link_index(link_index), .o_link_data(link_data),
        .o_exc_enter(exc_enter), .o_exc_mode(exc_mode), .o_exc_return(exc_return),
        .o_clear_from_writeback(o_clear_from_writeback),
        .o_fiq_ack(o_fiq_ack), .o_irq_ack(o_irq_ack)
);

zap_pc_counter u_pc (
        .i_clk(i_clk), .i_reset(i_reset), .i_code_stall(i_code_stall),
        .i_data_stall(i_data_stall), .i_pipe_stall(i_pipe_stall),
        .i_clear_from_alu(i_clear_from_alu), .i_pc_from_alu(i_pc_from_alu),
        .i_redirect(redirect), .i_redirect_pc(redirect_pc),
        .i_thumb(cpsr.f.t), .o_pc(o_pc)
);

// Bit 0 of a PC write selects the Thumb state.
zap_psr_fsm #(.PHY_REGS(PHY_REGS)) u_psr (
        .i_clk(i_clk), .i_reset(i_reset), .i_commit(commit),
        .i_wr_index(i_wr_index), .i_wr_data(i_wr_data), .i_flags(i_flags),
        .i_exc_enter(exc_enter), .i_exc_mode(exc_mode), .i_exc_return(exc_return),
        .i_pc_write_thumb(i_wr_data[0]), .o_cpsr(cpsr), .o_psr_flush(psr_flush)
);

zap_reg_bank #(.PHY_REGS(PHY_REGS)) u_bank (
        .i_clk(i_clk), .i_reset(i_reset), .i_commit(commit),
        .i_wr_index(i_wr_index), .i_wr_data(i_wr_data),
        .i_wr_index_1(i_wr_index_1), .i_wr_data_1(i_wr_data_1),
        .i_link_we(link_we), .i_link_index(link_index), .i_link_data(link_data),
        .i_pc(o_pc), .i_cpsr(cpsr.raw),
        .i_rd_index_0(i_rd_index_0), .i_rd_index_1(i_rd_index_1),
        .i_rd_index_2(i_rd_index_2), .i_rd_index_3(i_rd_index_3),
        .o_rd_data_0(o_rd_data_0), .o_rd_data_1(o_rd_data_1),
        .o_rd_data_2(o_rd_data_2), .o_rd_data_3(o_rd_data_3)
);

endmodule

// ==== verification/zap_writeback_asserts.sv ====
`timescale 1ns/100ps

module zap_writeback_asserts
(
        input logic i_clk,
        input logic i_reset,
        input logic i_flush,
        input logic i_fiq_ack,
        input logic i_irq_ack
);

// Only one interrupt is taken at a time.
ack_onehot: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_fiq_ack && i_irq_ack))
        else $error("FIQ and IRQ acknowledged in the same cycle");

// A taken interrupt always redirects the pipe.
ack_flush: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_fiq_ack || i_irq_ack) |-> i_flush)
        else $error("interrupt acknowledged without a flush");

// The first cycle out of reset is quiet.
reset_quiet: assert property (@(posedge i_clk) $fell(i_reset) |-> !i_flush)
        else $error("flush in the first cycle after reset");

endmodule

bind zap_writeback_top zap_writeback_asserts u_wb_asserts
(
        .i_clk(i_clk),
        .i_reset(i_reset),
        .i_flush(o_clear_from_writeback),
        .i_fiq_ack(o_fiq_ack),
        .i_irq_ack(o_irq_ack)
);

// ==== verification/tb_writeback.sv ====
`timescale 1ns/100ps

module tb_writeback;

// The five tests take about 1600 cycles in all.
localparam int MAX_CYCLES = 3000;

logic        i_clk = 1'b0;
logic        i_reset;
logic        i_valid;
logic        i_code_stall;
logic        i_data_stall;
logic        i_pipe_stall;
logic        i_clear_from_alu;
logic [31:0] i_pc_from_alu;
logic [4:0]  i_wr_index;
logic [31:0] i_wr_data;
logic [4:0]  i_wr_index_1;
logic [31:0] i_wr_data_1;
logic [3:0]  i_flags;
logic        i_flag_update;
logic        i_data_abt, i_fiq, i_irq, i_instr_abt, i_swi, i_und;
logic [31:0] i_pc_buf;
logic [31:0] i_vector_base;
logic [4:0]  i_rd_index_0, i_rd_index_1, i_rd_index_2, i_rd_index_3;
logic [31:0] o_rd_data_0, o_rd_data_1, o_rd_data_2, o_rd_data_3;
logic [31:0] o_pc;
logic [31:0] o_cpsr;
logic        o_clear_from_writeback;
logic        o_fiq_ack;
logic        o_irq_ack;

// Reference state.
logic [31:0] m_pc;
logic [31:0] m_cpsr;
logic [31:0] m_regs [22];
logic [31:0] m_spsr [5];
logic [31:0] rng;
int          checks = 0;
int          errors = 0;
int          cycles = 0;

// Exception table in rank order from data abort down to undefined.
logic [4:0]  exc_mode [6] = '{5'h17, 5'h11, 5'h12, 5'h17, 5'h13, 5'h1B};
logic [4:0]  link_idx [6] = '{5'd19, 5'd16, 5'd17, 5'd19, 5'd18, 5'd20};
logic [31:0] vec_off  [6] = '{32'h10, 32'h1C, 32'h18, 32'h0C, 32'h08, 32'h04};

zap_writeback_top #(.PHY_REGS(22)) dut (.*);

always #10 i_clk = ~i_clk;

always @(posedge i_clk)
begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES)
        begin
                $display("Timeout: the run did not finish within %0d cycles.", MAX_CYCLES);
                $display("*** TEST FAILED ***");
                $finish;
        end
end

function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
endfunction

function automatic logic [4:0] rand_index(input int lim);
        return 5'(next_rand() % 32'(lim));
endfunction

// Highest ranked pending exception or -1 when none.
function automatic int winner();
        logic [5:0] req;
        req = {i_und, i_swi, i_instr_abt, i_irq, i_fiq, i_data_abt};
        for (int k = 0; k < 6; k++)
                if (req[k])
                        return k;
        return -1;
endfunction

function automatic int spsr_slot_of(input logic [4:0] mode);
        case (mode)
                5'h11:   return 0;
                5'h12:   return 1;
                5'h13:   return 2;
                5'h17:   return 3;
                5'h1B:   return 4;
                default: return -1;
        endcase
endfunction

function automatic logic [31:0] expected_read(input logic [4:0] idx);
        if (idx == 5'd15)
                return m_pc;
        else if (idx == 5'd21)
                return m_cpsr;
        else if (idx < 5'd22)
                return m_regs[idx];
        return 32'd0;
endfunction

task automatic update_reg(input logic [4:0] idx, input logic [31:0] data);
        if ((idx != 5'd15) && (idx != 5'd21) && (idx < 5'd22))
                m_regs[idx] = data;
endtask

task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        assert (got == exp)
        else
        begin
                errors++;
                $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
endtask

task automatic drive_idle();
        {i_valid, i_code_stall, i_data_stall, i_pipe_stall, i_clear_from_alu} = '0;
        {i_data_abt, i_fiq, i_irq, i_instr_abt, i_swi, i_und, i_flag_update} = '0;
        {i_wr_index, i_wr_index_1, i_rd_index_0, i_rd_index_1} = '0;
        {i_rd_index_2, i_rd_index_3, i_flags} = '0;
        {i_pc_from_alu, i_wr_data, i_wr_data_1, i_pc_buf, i_vector_base} = '0;
endtask

task automatic random_reads();
        i_rd_index_0 = rand_index(22);
        i_rd_index_1 = rand_index(22);
        i_rd_index_2 = rand_index(22);
        i_rd_index_3 = rand_index(22);
endtask

// Checks the outputs of one cycle and advances the model at the edge.
task automatic run_cycle();
        int   w;
        int   s;
        logic exc;
        logic commit;
        logic pc_wr;
        logic user;
        logic psr_fl;
        w      = winner();
        exc    = (w >= 0);
        commit = i_valid && !exc;
        pc_wr  = commit && (i_wr_index == 5'd15);
        user   = (m_cpsr[4:0] == 5'h10);
        psr_fl = commit && (i_wr_index == 5'd21) && !user && (i_wr_data[7:0] != m_cpsr[7:0]);
        #5;
        expect_eq(32'(o_clear_from_writeback), 32'(exc || pc_wr || psr_fl), "flush");
        expect_eq(32'(o_fiq_ack), 32'(w == 1), "fiq ack");
        expect_eq(32'(o_irq_ack), 32'(w == 2), "irq ack");
        expect_eq(o_rd_data_0, expected_read(i_rd_index_0), "read port 0");
        expect_eq(o_rd_data_1, expected_read(i_rd_index_1), "read port 1");
        expect_eq(o_rd_data_2, expected_read(i_rd_index_2), "read port 2");
        expect_eq(o_rd_data_3, expected_read(i_rd_index_3), "read port 3");
        @(posedge i_clk);
        if (exc)
                m_pc = (i_vector_base + vec_off[w]) & ~32'd1;
        else if (pc_wr)
                m_pc = i_wr_data & ~32'd1;
        else if (!(i_code_stall || i_data_stall))
        begin
                if (i_clear_from_alu)
                        m_pc = i_pc_from_alu;
                else if (!i_pipe_stall)
                        m_pc = m_pc + (m_cpsr[5] ? 32'd2 : 32'd4);
        end
        if (commit)
        begin
                update_reg(i_wr_index, i_wr_data);
                update_reg(i_wr_index_1, i_wr_data_1);
        end
        if (exc)
        begin
                // Data aborts keep the buffered PC and the rest step back a word.
                update_reg(link_idx[w], (w == 0) ? i_pc_buf : i_pc_buf - 32'd4);
                m_spsr[spsr_slot_of(exc_mode[w])] = m_cpsr;
                m_cpsr[4:0] = exc_mode[w];
                m_cpsr[5]   = 1'b0;
        end
        else if (pc_wr && i_flag_update)
        begin
                s = spsr_slot_of(m_cpsr[4:0]);
                if (s >= 0)
                        m_cpsr = m_spsr[s];
        end
        else if (commit)
        begin
                if (i_wr_index == 5'd21)
                        m_cpsr = user ? {i_wr_data[31:8], m_cpsr[7:0]} : i_wr_data;
                else
                        m_cpsr[31:28] = i_flags;
                if (pc_wr)
                        m_cpsr[5] = i_wr_data[0];
        end
        #1;
        expect_eq(o_pc, m_pc, "o_pc");
        expect_eq(o_cpsr, m_cpsr, "o_cpsr");
endtask

task automatic enter_exception(output int won);
        drive_idle();
        {i_und, i_swi, i_instr_abt, i_irq, i_fiq, i_data_abt} = 6'(next_rand() % 32'd63 + 32'd1);
        i_valid       = (next_rand() % 32'd2) == 32'd0;
        i_wr_index    = rand_index(15);
        i_wr_data     = next_rand();
        i_pc_buf      = next_rand();
        i_vector_base = next_rand() & 32'hFFFF_FF00;
        won = winner();
        run_cycle();
        expect_eq(32'(o_cpsr[4:0]), 32'(exc_mode[won]), "mode after entry");
endtask

task automatic return_from_exception();
        drive_idle();
        i_valid       = 1'b1;
        i_flag_update = 1'b1;
        i_wr_index    = 5'd15;
        i_wr_data     = next_rand();
        run_cycle();
endtask

task automatic cpsr_write(input logic [31:0] data);
        drive_idle();
        i_valid    = 1'b1;
        i_wr_index = 5'd21;
        i_wr_data  = data;
        random_reads();
        run_cycle();
endtask

task automatic report_test(input int num, input string name, input int err0, input int chk0);
        $display("test %0d %s finished: %0d checks, %0d errors",
                 num, name, checks - chk0, errors - err0);
endtask

initial
begin
        int          err0;
        int          chk0;
        int          won;
        logic        thumb;
        logic [31:0] prev;
        rng = 32'hf758;
        drive_idle();
        i_reset = 1'b1;
        m_pc    = 32'd0;
        m_cpsr  = 32'h13;
        for (int i = 0; i < 22; i++)
                m_regs[i] = 32'd0;
        for (int i = 0; i < 5; i++)
                m_spsr[i] = 32'd0;
        repeat (4) @(posedge i_clk);
        #1;
        i_reset = 1'b0;

        err0 = errors;
        chk0 = checks;
        expect_eq(o_pc, 32'd0, "pc after reset");
        expect_eq(o_cpsr, 32'h13, "cpsr after reset");
        for (int n = 0; n < 400; n++)
        begin
                drive_idle();
                i_code_stall     = (next_rand() % 32'd8) == 32'd0;
                i_data_stall     = (next_rand() % 32'd8) == 32'd0;
                i_pipe_stall     = (next_rand() % 32'd4) == 32'd0;
                i_clear_from_alu = (next_rand() % 32'd6) == 32'd0;
                i_pc_from_alu    = next_rand();
                random_reads();
                run_cycle();
        end
        report_test(1, "reset and pc sequencing", err0, chk0);

        err0 = errors;
        chk0 = checks;
        for (int n = 0; n < 400; n++)
        begin
                drive_idle();
                i_valid      = (next_rand() % 32'd4) != 32'd0;
                i_wr_index   = rand_index(15);
                // Equal indexes now and then, so port 1 has to win.
                i_wr_index_1 = ((next_rand() % 32'd4) == 32'd0) ? i_wr_index : rand_index(15);
                i_wr_data    = next_rand();
                i_wr_data_1  = next_rand();
                i_flags      = 4'(next_rand());
                i_pipe_stall = (next_rand() % 32'd4) == 32'd0;
                random_reads();
                run_cycle();
        end
        report_test(2, "register writes and reads", err0, chk0);

        err0 = errors;
        chk0 = checks;
        for (int n = 0; n < 100; n++)
        begin
                enter_exception(won);
                drive_idle();
                i_rd_index_0 = link_idx[won];
                i_rd_index_1 = 5'd21;
                i_pipe_stall = 1'b1;
                run_cycle();
                return_from_exception();
        end
        report_test(3, "exception entry", err0, chk0);

        err0 = errors;
        chk0 = checks;
        for (int n = 0; n < 100; n++)
        begin
                drive_idle();
                i_valid    = 1'b1;
                i_wr_index = rand_index(15);
                i_wr_data  = next_rand();
                i_flags    = 4'(next_rand());
                run_cycle();
                prev = m_cpsr;
                enter_exception(won);
                return_from_exception();
                expect_eq(o_cpsr, prev, "cpsr after return");
        end
        report_test(4, "exception return", err0, chk0);

        err0 = errors;
        chk0 = checks;
        // Drop from SVC to user mode.
        cpsr_write((next_rand() & 32'hFFFF_FF00) | 32'h10);
        for (int n = 0; n < 40; n++)
        begin
                cpsr_write(next_rand());
                expect_eq(32'(o_cpsr[7:0]), 32'h10, "user low byte");
        end
        drive_idle();
        i_swi    = 1'b1;
        i_pc_buf = next_rand();
        run_cycle();
        for (int n = 0; n < 40; n++)
                cpsr_write((next_rand() & 32'hFFFF_FFE0) | 32'h13);
        for (int n = 0; n < 20; n++)
        begin
                drive_idle();
                i_valid    = 1'b1;
                i_wr_index = 5'd15;
                i_wr_data  = next_rand();
                thumb      = i_wr_data[0];
                run_cycle();
                for (int k = 0; k < 3; k++)
                begin
                        drive_idle();
                        prev = m_pc;
                        run_cycle();
                        expect_eq(o_pc, prev + (thumb ? 32'd2 : 32'd4), "pc step");
                end
        end
        report_test(5, "mode protection and thumb", err0, chk0);

        $display("summary: 5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0)
                $display("*** TEST PASSED ***");
        else
                $display("*** TEST FAILED ***");
        $finish;
end

endmodule

// ==== project.f ====
hw/zap_wb_pkg.sv
hw/zap_pc_counter.sv
hw/zap_psr_fsm.sv
hw/zap_redirect_ctrl.sv
hw/zap_reg_bank.sv
hw/zap_writeback_top.sv
verification/zap_writeback_asserts.sv
verification/tb_writeback.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the writeback testbench with Verilator, runs it and checks the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_writeback -f project.f -o sim_writeback

./obj_dir/sim_writeback 2>&1 | tee sim.log

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
        echo "Simulation failed, see sim.log"
        exit 1
fi
echo "Simulation passed"
